// File: bcore_pkg.sv
package bcore_pkg;

  localparam int LANES     = 4;                  // Instructions per bundle
  localparam int XLEN      = 32;                 // Datapath width
  localparam int REG_NUM_W = 5;                  // Register number width
  localparam int NUM_REGS  = 32;                 // r0 hardwired to zero
  localparam int BUNDLE_W  = LANES * XLEN;       // Lane 0 in the low word
  localparam int SHAMT_W   = 5;                  // Shift distance 0..31
  localparam int OPC_W     = 4;
  localparam int IMM_W     = 13;                 // Raw immediate before sign extension

  localparam int OPC_HI    = 31;                 // Opcode field
  localparam int OPC_LO    = 28;
  localparam int RD_HI     = 27;                 // Destination register
  localparam int RD_LO     = 23;
  localparam int RS_HI     = 22;                 // First source
  localparam int RS_LO     = 18;
  localparam int RT_HI     = 17;                 // Second source
  localparam int RT_LO     = 13;
  localparam int IMM_HI    = 12;                 // Immediate, sign bit at the top
  localparam int IMM_LO    = 0;
  localparam int SHT_HI    = 6;                  // Shift type, overlaps imm
  localparam int SHT_LO    = 5;
  localparam int SHAMT_HI  = 4;                  // Shift amount, overlaps imm
  localparam int SHAMT_LO  = 0;

  typedef enum logic [OPC_W-1:0] {
    OP_NOP   = 4'd0,                             // No write, never illegal
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_ADDI  = 4'd6,                             // rs plus sign-extended imm
    OP_SHIFT = 4'd7                              // Codes 8..15 are illegal
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHIFT
  } alu_op_t;

  typedef enum logic [1:0] {
    SH_LL = 2'd0,                                // Logical left
    SH_RL = 2'd1,                                // Logical right
    SH_RA = 2'd2                                 // Arithmetic right, code 3 illegal
  } shift_type_t;

endpackage

// File: dec_if.sv
`timescale 1ns/1ns

interface dec_if import bcore_pkg::*; ();

  logic                 valid;                   // Bundle held in the d2pc stage
  alu_op_t              alu_op       [LANES];
  shift_type_t          shift_type   [LANES];
  logic [SHAMT_W-1:0]   shift_amount [LANES];
  logic                 use_imm      [LANES];    // Operand b from imm, not rt
  logic [XLEN-1:0]      imm          [LANES];    // Already sign-extended
  logic [REG_NUM_W-1:0] rd_num       [LANES];
  logic                 rd_we        [LANES];    // Legal, non-NOP, rd not r0
  logic                 illegal      [LANES];

  modport dcd (
    output valid, alu_op, shift_type, shift_amount, use_imm, imm,
    output rd_num, rd_we, illegal
  );

  modport exe (
    input valid, alu_op, shift_type, shift_amount, use_imm, imm,
    input rd_num, rd_we, illegal
  );

endinterface

// File: wb_if.sv
`timescale 1ns/1ns

interface wb_if import bcore_pkg::*; ();

  logic                 valid;                   // Bundle leaving execute
  logic                 we   [LANES];            // Already qualified by valid
  logic [REG_NUM_W-1:0] num  [LANES];
  logic [XLEN-1:0]      data [LANES];

  modport exe (
    output valid, we, num, data
  );

  modport rf (
    input valid, we, num, data
  );

endinterface

// File: bundle_decode.sv
`timescale 1ns/1ns

module bundle_decode import bcore_pkg::*; (
  input  logic                clkrst_core_clk,
  input  logic                arst_n,
  input  logic                bundle_valid,
  input  logic [BUNDLE_W-1:0] bundle,
  dec_if.dcd                  dcd
);

  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      dcd.valid <= 1'b0;
    end else begin
      dcd.valid <= bundle_valid;                 // Strobe moves into d2pc stage
    end
  end

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [XLEN-1:0]      inst;
    opcode_t              opc;
    logic [REG_NUM_W-1:0] rd;
    alu_op_t              op;
    logic                 use_imm;
    logic                 legal;
    logic                 we;

    assign inst = bundle[i*XLEN +: XLEN];        // Lane i slice
    assign opc  = opcode_t'(inst[OPC_HI:OPC_LO]);
    assign rd   = inst[RD_HI:RD_LO];

    always_comb begin
      op      = ALU_ADD;                         // NOP falls through as add
      use_imm = 1'b0;
      legal   = 1'b1;
      case (opc)
        OP_NOP:   op = ALU_ADD;
        OP_ADD:   op = ALU_ADD;
        OP_SUB:   op = ALU_SUB;
        OP_AND:   op = ALU_AND;
        OP_OR:    op = ALU_OR;
        OP_XOR:   op = ALU_XOR;
        OP_ADDI: begin
          op      = ALU_ADD;
          use_imm = 1'b1;
        end
        OP_SHIFT: begin
          op    = ALU_SHIFT;
          legal = (inst[SHT_HI:SHT_LO] != 2'd3); // Type 3 is undefined
        end
        default:  legal = 1'b0;                  // Opcodes 8..15
      endcase
    end

    assign we = legal && (opc != OP_NOP) && (rd != '0); // r0 writes dropped here

    always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
      if (!arst_n) begin
        dcd.rd_we[i]   <= 1'b0;
        dcd.illegal[i] <= 1'b0;
      end else begin
        dcd.rd_we[i]   <= we;
        dcd.illegal[i] <= ~legal;
      end
    end

    always_ff @(posedge clkrst_core_clk) begin
      dcd.alu_op[i]       <= op;
      dcd.shift_type[i]   <= shift_type_t'(inst[SHT_HI:SHT_LO]);
      dcd.shift_amount[i] <= inst[SHAMT_HI:SHAMT_LO];
      dcd.use_imm[i]      <= use_imm;
      dcd.imm[i]          <= {{(XLEN-IMM_W){inst[IMM_HI]}}, inst[IMM_HI:IMM_LO]};
      dcd.rd_num[i]       <= rd;
    end
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file import bcore_pkg::*; (
  input  logic                   clkrst_core_clk,
  input  logic                   arst_n,
  input  logic [BUNDLE_W-1:0]    bundle,
  wb_if.rf                       wb,
  output logic [LANES*XLEN-1:0]  rs_data,
  output logic [LANES*XLEN-1:0]  rt_data
);

  logic [XLEN-1:0] regs [NUM_REGS];              // Architectural registers

  // r0 is never written, but the read mux forces zero as well
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_NUM_W-1:0] num);
    logic [XLEN-1:0] val;
    val = (num == '0) ? '0 : regs[num];
    return val;
  endfunction

  // Operand pairs for all lanes, sampled from pre-edge contents
  always_ff @(posedge clkrst_core_clk) begin
    for (int i = 0; i < LANES; i++) begin
      rs_data[i*XLEN +: XLEN] <= read_reg(bundle[i*XLEN + RS_LO +: REG_NUM_W]);
      rt_data[i*XLEN +: XLEN] <= read_reg(bundle[i*XLEN + RT_LO +: REG_NUM_W]);
    end
  end

  // Write ports walked in lane order so lane 3 lands last
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};                    // All registers read zero after reset
    end else if (wb.valid) begin
      for (int i = 0; i < LANES; i++) begin
        if (wb.we[i] && (wb.num[i] != '0)) begin
          regs[wb.num[i]] <= wb.data[i];         // Later lane overrides earlier
        end
      end
    end
  end

endmodule

// File: lane_alu.sv
`timescale 1ns/1ns

module lane_alu import bcore_pkg::*; (
  input  alu_op_t            alu_op,
  input  shift_type_t        shift_type,
  input  logic [SHAMT_W-1:0] shift_amount,
  input  logic [XLEN-1:0]    op_a,               // Always rs
  input  logic [XLEN-1:0]    op_b,               // rt or immediate
  output logic [XLEN-1:0]    result
);

  logic [XLEN-1:0] shifted;

  always_comb begin
    case (shift_type)
      SH_LL:   shifted = op_a << shift_amount;
      SH_RL:   shifted = op_a >> shift_amount;
      SH_RA:   shifted = $signed(op_a) >>> shift_amount; // Sign bit replicated
      default: shifted = op_a;                   // Type 3, lane marked illegal
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD:   result = op_a + op_b;           // Wraps mod 2^XLEN
      ALU_SUB:   result = op_a - op_b;
      ALU_AND:   result = op_a & op_b;
      ALU_OR:    result = op_a | op_b;
      ALU_XOR:   result = op_a ^ op_b;
      ALU_SHIFT: result = shifted;
      default:   result = op_a;
    endcase
  end

endmodule

// File: bundle_execute.sv
`timescale 1ns/1ns

module bundle_execute import bcore_pkg::*; (
  input  logic                        clkrst_core_clk,
  input  logic                        arst_n,
  dec_if.exe                          dcd,
  input  logic [LANES*XLEN-1:0]       rs_data,
  input  logic [LANES*XLEN-1:0]       rt_data,
  wb_if.exe                           wb,
  output logic                        wb_valid,
  output logic [LANES-1:0]            wb_we,
  output logic [LANES-1:0]            wb_illegal,
  output logic [LANES*REG_NUM_W-1:0]  wb_num,
  output logic [LANES*XLEN-1:0]       wb_data
);

  logic [XLEN-1:0] result [LANES];

  assign wb.valid = dcd.valid;                   // Regfile commits on the pc2wb edge

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [XLEN-1:0] op_b;

    assign op_b = dcd.use_imm[i] ? dcd.imm[i] : rt_data[i*XLEN +: XLEN];

    lane_alu i_alu (
      .alu_op       (dcd.alu_op[i]),
      .shift_type   (dcd.shift_type[i]),
      .shift_amount (dcd.shift_amount[i]),
      .op_a         (rs_data[i*XLEN +: XLEN]),
      .op_b         (op_b),
      .result       (result[i])
    );

    assign wb.we[i]   = dcd.valid & dcd.rd_we[i]; // No write without a bundle
    assign wb.num[i]  = dcd.rd_num[i];
    assign wb.data[i] = result[i];
  end

  // pc2wb stage control
  always_ff @(posedge clkrst_core_clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid   <= 1'b0;
      wb_we      <= '0;
      wb_illegal <= '0;
    end else begin
      wb_valid <= dcd.valid;
      for (int i = 0; i < LANES; i++) begin
        wb_we[i]      <= wb.we[i];
        wb_illegal[i] <= dcd.valid & dcd.illegal[i];
      end
    end
  end

  // pc2wb stage payload
  always_ff @(posedge clkrst_core_clk) begin
    for (int i = 0; i < LANES; i++) begin
      wb_num[i*REG_NUM_W +: REG_NUM_W] <= dcd.rd_num[i];
      wb_data[i*XLEN +: XLEN]          <= result[i];
    end
  end

endmodule

// File: bcore.sv
`timescale 1ns/1ns

module bcore import bcore_pkg::*; (
  input  logic                        clkrst_core_clk,
  input  logic                        arst_n,
  input  logic                        bundle_valid,  // One-cycle strobe, no back-pressure
  input  logic [BUNDLE_W-1:0]         bundle,
  output logic                        wb_valid,      // Two edges after the strobe
  output logic [LANES-1:0]            wb_we,
  output logic [LANES-1:0]            wb_illegal,
  output logic [LANES*REG_NUM_W-1:0]  wb_num,
  output logic [LANES*XLEN-1:0]       wb_data
);

  logic [LANES*XLEN-1:0] rs_data;                // Registered operand pairs
  logic [LANES*XLEN-1:0] rt_data;

  dec_if dec_bus ();                             // Decode to execute
  wb_if  wb_bus ();                              // Execute to regfile writes

  // Decode and operand read run side by side in the first cycle
  bundle_decode i_decode (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bundle_valid    (bundle_valid),
    .bundle          (bundle),
    .dcd             (dec_bus.dcd)
  );

  reg_file i_reg_file (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bundle          (bundle),
    .wb              (wb_bus.rf),
    .rs_data         (rs_data),
    .rt_data         (rt_data)
  );

  bundle_execute i_execute (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .dcd             (dec_bus.exe),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .wb              (wb_bus.exe),
    .wb_valid        (wb_valid),
    .wb_we           (wb_we),
    .wb_illegal      (wb_illegal),
    .wb_num          (wb_num),
    .wb_data         (wb_data)
  );

endmodule

// File: bcore_chk.sv
`timescale 1ns/1ns

module bcore_chk import bcore_pkg::*; (
  input logic                       clkrst_core_clk,
  input logic                       arst_n,
  input logic                       bundle_valid,
  input logic [BUNDLE_W-1:0]        bundle,
  input logic                       wb_valid,
  input logic [LANES-1:0]           wb_we,
  input logic [LANES-1:0]           wb_illegal,
  input logic [LANES*REG_NUM_W-1:0] wb_num,
  input logic [LANES*XLEN-1:0]      wb_data
);

  int err_count = 0;                             // Bumped by every failing assertion

  logic [XLEN-1:0]      ref_regs [NUM_REGS];     // Architectural state as seen by software
  logic                 s1_valid;                // Bundle sampled at the last edge
  logic [LANES-1:0]     s1_we;
  logic [LANES-1:0]     s1_ill;
  logic [LANES-1:0]     s1_chk;                  // Lane result is defined
  logic [REG_NUM_W-1:0] s1_num  [LANES];
  logic [XLEN-1:0]      s1_data [LANES];
  logic [LANES-1:0]     s2_we;                   // Bundle now on the wb_* outputs
  logic [LANES-1:0]     s2_ill;
  logic [LANES-1:0]     s2_chk;
  logic [REG_NUM_W-1:0] s2_num  [LANES];
  logic [XLEN-1:0]      s2_data [LANES];

  function automatic logic [XLEN-1:0] reg_value(input logic [REG_NUM_W-1:0] num);
    return (num == '0) ? '0 : ref_regs[num];     // r0 hardwired
  endfunction

  function automatic logic lane_legal(input logic [XLEN-1:0] inst);
    logic [OPC_W-1:0] opc;
    opc = inst[OPC_HI:OPC_LO];
    if (opc > 4'd7) begin
      return 1'b0;
    end
    return !((opc == OP_SHIFT) && (inst[SHT_HI:SHT_LO] == 2'd3));
  endfunction

  function automatic logic [XLEN-1:0] lane_result(input logic [XLEN-1:0] inst);
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    logic [XLEN-1:0]    imm;
    logic [SHAMT_W-1:0] amt;
    a   = reg_value(inst[RS_HI:RS_LO]);
    b   = reg_value(inst[RT_HI:RT_LO]);
    imm = XLEN'($signed(inst[IMM_HI:IMM_LO]));  // Signed widening
    amt = inst[SHAMT_HI:SHAMT_LO];
    case (inst[OPC_HI:OPC_LO])
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + imm;
      OP_SHIFT: begin
        case (inst[SHT_HI:SHT_LO])
          2'd0:    return a << amt;
          2'd1:    return a >> amt;
          2'd2:    return (a >> amt) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> amt) : '0); // Sign fill mask
          default: return '0;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  always @(posedge clkrst_core_clk or negedge arst_n) begin : model
    logic [XLEN-1:0] inst;
    if (!arst_n) begin
      ref_regs <= '{default: '0};
      s1_valid <= 1'b0;
      s1_we    <= '0;
      s1_ill   <= '0;
      s1_chk   <= '0;
      s2_we    <= '0;
      s2_ill   <= '0;
      s2_chk   <= '0;
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (s1_valid && s1_we[i]) begin
          ref_regs[s1_num[i]] <= s1_data[i];     // Lane order, so lane 3 lands last
        end
        inst = bundle[i*XLEN +: XLEN];
        s1_we[i]   <= bundle_valid && lane_legal(inst) && (inst[OPC_HI:OPC_LO] != OP_NOP)
                      && (inst[RD_HI:RD_LO] != '0);
        s1_ill[i]  <= bundle_valid && !lane_legal(inst);
        s1_chk[i]  <= bundle_valid && lane_legal(inst) && (inst[OPC_HI:OPC_LO] != OP_NOP);
        s1_num[i]  <= inst[RD_HI:RD_LO];
        s1_data[i] <= lane_result(inst);         // Reads state before this edge's commit
      end
      s1_valid <= bundle_valid;
      s2_we    <= s1_we;
      s2_ill   <= s1_ill;
      s2_chk   <= s1_chk;
      s2_num   <= s1_num;
      s2_data  <= s1_data;
    end
  end

  a_latency: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    bundle_valid |-> ##2 wb_valid)
    else begin
      err_count++;
      $error("write-back did not appear two cycles after a strobe");
    end

  a_origin: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    wb_valid |-> $past(bundle_valid, 2))
    else begin
      err_count++;
      $error("write-back appeared without a strobe two cycles earlier");
    end

  a_quiet: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    !wb_valid |-> (wb_we == '0) && (wb_illegal == '0))
    else begin
      err_count++;
      $error("write enable or illegal flag raised while no write-back is valid");
    end

  a_ctrl: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
    wb_valid |-> (wb_we == s2_we) && (wb_illegal == s2_ill))
    else begin
      err_count++;
      $error("ERROR t=%0t: wb_we %b wb_illegal %b, expected %b %b", $time,
             $sampled(wb_we), $sampled(wb_illegal), $sampled(s2_we), $sampled(s2_ill));
    end

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    a_data: assert property (@(posedge clkrst_core_clk) disable iff (!arst_n)
      (wb_valid && s2_chk[i]) |-> (wb_data[i*XLEN +: XLEN] == s2_data[i])
                                  && (wb_num[i*REG_NUM_W +: REG_NUM_W] == s2_num[i]))
      else begin
        err_count++;
        $error("ERROR t=%0t: lane %0d wb_data %h wb_num %0d, expected %h %0d", $time, i,
               $sampled(wb_data[i*XLEN +: XLEN]), $sampled(wb_num[i*REG_NUM_W +: REG_NUM_W]),
               $sampled(s2_data[i]), $sampled(s2_num[i]));
      end
  end

endmodule

bind bcore bcore_chk i_chk (
  .clkrst_core_clk (clkrst_core_clk),
  .arst_n          (arst_n),
  .bundle_valid    (bundle_valid),
  .bundle          (bundle),
  .wb_valid        (wb_valid),
  .wb_we           (wb_we),
  .wb_illegal      (wb_illegal),
  .wb_num          (wb_num),
  .wb_data         (wb_data)
);

// File: bcore_tb.sv
`timescale 1ns/1ns

module bcore_tb import bcore_pkg::*; ();

  localparam int N_INIT      = 8;                // ADDI loads, four registers per bundle
  localparam int N_DIRECTED  = 33;
  localparam int N_RANDOM    = 150;
  localparam int N_BUNDLES   = N_INIT + N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = 4 * N_BUNDLES + 100;
  localparam logic [XLEN-1:0] NOP_INST = '0;

  logic                       clkrst_core_clk = 1'b0;
  logic                       arst_n;
  logic                       bundle_valid;
  logic [BUNDLE_W-1:0]        bundle;
  logic                       wb_valid;
  logic [LANES-1:0]           wb_we;
  logic [LANES-1:0]           wb_illegal;
  logic [LANES*REG_NUM_W-1:0] wb_num;
  logic [LANES*XLEN-1:0]      wb_data;
  integer                     seed;
  int                         issued    = 0;
  int                         wb_seen   = 0;
  int                         tb_errors = 0;

  bcore i_dut (
    .clkrst_core_clk (clkrst_core_clk),
    .arst_n          (arst_n),
    .bundle_valid    (bundle_valid),
    .bundle          (bundle),
    .wb_valid        (wb_valid),
    .wb_we           (wb_we),
    .wb_illegal      (wb_illegal),
    .wb_num          (wb_num),
    .wb_data         (wb_data)
  );

  always #10 clkrst_core_clk = ~clkrst_core_clk; // 20 ns period

  always @(posedge clkrst_core_clk) begin
    if (wb_valid) begin
      wb_seen++;                                 // Pre-edge value, no race with the DUT
    end
  end

  function automatic logic [XLEN-1:0] alu_inst(input logic [3:0] op,
                                               input logic [4:0] rd, rs, rt);
    return {op, rd, rs, rt, 13'd0};
  endfunction

  function automatic logic [XLEN-1:0] addi_inst(input logic [4:0] rd, rs,
                                                input logic [12:0] imm);
    return {OP_ADDI, rd, rs, 5'd0, imm};
  endfunction

  function automatic logic [XLEN-1:0] shift_inst(input logic [4:0] rd, rs,
                                                 input logic [1:0] sht,
                                                 input logic [4:0] amt);
    return {OP_SHIFT, rd, rs, 5'd0, 6'd0, sht, amt};
  endfunction

  function automatic logic [XLEN-1:0] rand_inst();
    logic [XLEN-1:0] r;
    int unsigned     pick;
    logic [3:0]      op;
    r    = $random(seed);
    pick = $unsigned($random(seed)) % 7;
    op   = pick[3:0] + 4'd1;                     // Legal opcodes 1..7
    if (op == OP_SHIFT) begin
      pick = $unsigned($random(seed)) % 3;       // Legal shift types only
      return shift_inst(r[27:23], r[22:18], pick[1:0], r[4:0]);
    end
    return {op, r[27:0]};
  endfunction

  task automatic send(input logic [XLEN-1:0] l0, l1, l2, l3);
    @(posedge clkrst_core_clk);
    bundle_valid <= 1'b1;
    bundle       <= {l3, l2, l1, l0};            // Lane 0 in the low word
    issued++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clkrst_core_clk);
      bundle_valid <= 1'b0;
    end
  endtask

  task automatic print_counts();
    $display("bundles %0d, write-backs %0d, assertion errors %0d, testbench errors %0d",
             issued, wb_seen, i_dut.i_chk.err_count, tb_errors);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clkrst_core_clk);
      cycles++;
    end
    $display("timeout: write-back never completed");
    print_counts();
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    seed         = 32'h762b_69cd;
    arst_n       = 1'b0;
    bundle_valid = 1'b0;
    bundle       = '0;
    repeat (8) @(posedge clkrst_core_clk);
    arst_n <= 1'b1;
    idle(3);                                     // Quiet window before the first strobe
    for (int b = 0; b < N_INIT; b++) begin       // Back to back, r0 slot gives rd 0
      send(addi_inst(5'(4 * b), 5'd0, 13'($random(seed))),
           addi_inst(5'(4 * b + 1), 5'd0, 13'($random(seed))),
           addi_inst(5'(4 * b + 2), 5'd0, 13'($random(seed))),
           addi_inst(5'(4 * b + 3), 5'd0, 13'($random(seed))));
    end
    idle(1);
    send(addi_inst(5'd29, 5'd0, 13'h0abc), addi_inst(5'd30, 5'd0, 13'h1a5a), NOP_INST, NOP_INST);
    idle(1);
    // r1 rewritten, next bundle sees old r1, the one after sees new r1
    send(alu_inst(OP_ADD, 5'd1, 5'd2, 5'd3), alu_inst(OP_SUB, 5'd4, 5'd5, 5'd6),
         alu_inst(OP_AND, 5'd7, 5'd1, 5'd8), alu_inst(OP_XOR, 5'd9, 5'd4, 5'd1));
    send(alu_inst(OP_ADD, 5'd10, 5'd1, 5'd0), alu_inst(OP_OR, 5'd11, 5'd4, 5'd0),
         NOP_INST, NOP_INST);
    send(alu_inst(OP_ADD, 5'd12, 5'd1, 5'd0), alu_inst(OP_OR, 5'd13, 5'd4, 5'd2),
         addi_inst(5'd1, 5'd1, 13'h1fff), NOP_INST);
    idle(1);
    send(addi_inst(5'd5, 5'd0, 13'd11), addi_inst(5'd5, 5'd0, 13'd22),
         alu_inst(OP_ADD, 5'd14, 5'd2, 5'd3), addi_inst(5'd5, 5'd0, 13'd33)); // r5 conflict
    idle(1);
    send(alu_inst(OP_ADD, 5'd6, 5'd5, 5'd0), NOP_INST, NOP_INST, NOP_INST);
    idle(1);
    send({4'd9, 28'h1a2_b3c4}, {4'hf, 28'h0c0_ffee}, shift_inst(5'd15, 5'd2, 2'd3, 5'd7),
         alu_inst(OP_AND, 5'd16, 5'd2, 5'd3));  // Two bad opcodes and shift type 3
    idle(1);
    send(addi_inst(5'd0, 5'd1, 13'd100), alu_inst(OP_OR, 5'd0, 5'd2, 5'd3), NOP_INST, NOP_INST);
    idle(1);
    send(alu_inst(OP_ADD, 5'd17, 5'd0, 5'd0), alu_inst(OP_OR, 5'd18, 5'd0, 5'd2),
         NOP_INST, NOP_INST);
    idle(1);
    for (int t = 0; t < 3; t++) begin            // Every type and amount, r30 negative
      for (int a = 0; a < 32; a += 4) begin
        send(shift_inst(5'd20, 5'd30, 2'(t), 5'(a)), shift_inst(5'd21, 5'd29, 2'(t), 5'(a + 1)),
             shift_inst(5'd22, 5'd30, 2'(t), 5'(a + 2)),
             shift_inst(5'd23, 5'd29, 2'(t), 5'(a + 3)));
      end
    end
    idle(1);
    for (int n = 0; n < N_RANDOM; n++) begin
      send(rand_inst(), rand_inst(), rand_inst(), rand_inst());
      idle($unsigned($random(seed)) % 3);        // Gaps of 0..2 cycles
    end
    idle(1);
    while (wb_seen < issued) begin
      @(posedge clkrst_core_clk);
    end
    repeat (2) @(posedge clkrst_core_clk);       // Let the last assertions mature
    if (wb_seen != N_BUNDLES) begin
      tb_errors++;
      $display("ERROR t=%0t: %0d write-backs for %0d bundles sent", $time, wb_seen, N_BUNDLES);
    end
    print_counts();
    if ((i_dut.i_chk.err_count == 0) && (tb_errors == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: bcore.f
bcore_pkg.sv
dec_if.sv
wb_if.sv
bundle_decode.sv
reg_file.sv
lane_alu.sv
bundle_execute.sv
bcore.sv
bcore_chk.sv
bcore_tb.sv
